/* source/mmio_csr_pkg.sv */
// MMIO test register block
// Shared bus types and register map

package mmio_csr_pkg;

    // ========================================
    // Wide bus types
    // ========================================

    // Address is an index of 512-bit words, byte 64 per step
    localparam int IDX_WIDTH = 12;

    typedef logic [IDX_WIDTH-1:0] t_csr_idx;

    // Same 512-bit word seen either as flat bits or as eight 64-bit registers
    typedef union packed {
        logic [511:0]      bits;
        logic [7:0][63:0]  words;
    } t_mmio_value;

    // One enable bit per byte of the wide word
    typedef logic [63:0] t_byte_mask;

    // Snapshot of the most recent accepted write
    typedef struct packed {
        t_mmio_value data;
        t_byte_mask  mask;
        t_csr_idx    idx;
        // Byte offset of the access inside the wide word
        logic [5:0]  byte_idx;
    } t_wr_state;

    // ========================================
    // Register map, in 512-bit word indexes
    // ========================================

    localparam t_csr_idx IDX_DFH        = t_csr_idx'(0);
    localparam t_csr_idx IDX_STATUS     = t_csr_idx'(2);
    localparam t_csr_idx IDX_WR64_DATA  = t_csr_idx'(4);
    localparam t_csr_idx IDX_WR64_INFO  = t_csr_idx'(6);
    localparam t_csr_idx IDX_WR512_DATA = t_csr_idx'(8);
    localparam t_csr_idx IDX_WR512_INFO = t_csr_idx'(10);

    // Position of the lowest set enable bit, 64 when the mask is empty
    // The byte offset of a narrow access equals this position
    function automatic logic [6:0] lowest_byte(input t_byte_mask mask);
        logic [6:0] pos;
        pos = 7'd64;
        for (int i = 63; i >= 0; i--)
        begin
            if (mask[i])
            begin
                pos = 7'(i);
            end
        end
        return pos;
    endfunction

endpackage

/* source/mmio_avalon_if.sv */
// Wide MMIO bus

`timescale 1ns/1ps

interface mmio_avalon_if
    import mmio_csr_pkg::*;
(
    input logic clk,
    input logic reset_n
);

    // Request side, driven by the width adapter
    t_csr_idx    address;
    logic        read;
    logic        write;
    t_byte_mask  byteenable;
    t_mmio_value writedata;

    // Response side
    // Stall comes from the pattern generator, data from the read pipeline
    logic        waitrequest;
    t_mmio_value readdata;
    logic        readdatavalid;

    // Adapter has its own clock and reset ports
    modport requester (
        output address, read, write, byteenable, writedata,
        input  waitrequest, readdata, readdatavalid
    );

    // Only the stall generator owns waitrequest
    modport stall (
        input  clk, reset_n,
        output waitrequest
    );

    // Write capture only observes the bus
    modport capture (
        input clk, reset_n, address, write, byteenable, writedata, waitrequest
    );

    // Read pipeline answers reads
    modport responder (
        input  clk, reset_n, address, read, byteenable, waitrequest,
        output readdata, readdatavalid
    );

endinterface

/* source/mmio_stall_gen.sv */
// Rotating waitrequest generator

`timescale 1ns/1ps

module mmio_stall_gen #(
    // One bit per cycle, rotated left, bit 8 is the stall
    parameter logic [15:0] STALL_PATTERN = 16'hfffe
) (
    mmio_avalon_if.stall bus
);

    // ========================================
    // Stall pattern
    // ========================================

    logic [15:0] pattern_q;

    // Reload on reset so the first free slot lands at a fixed cycle
    // With the default pattern the zero reaches bit 8 after 8 rotations
    always_ff @(posedge bus.clk)
    begin
        if (!bus.reset_n)
        begin
            pattern_q <= STALL_PATTERN;
        end
        else
        begin
            // Rotate left by one
            pattern_q <= {pattern_q[14:0], pattern_q[15]};
        end
    end

    // Every requester sees the same stall
    assign bus.waitrequest = pattern_q[8];

endmodule

/* source/mmio_width_adapter.sv */
// Host to wide bus width adapter
// Places 64-bit accesses in a lane, picks the lane back out of read data

`timescale 1ns/1ps

module mmio_width_adapter
    import mmio_csr_pkg::*;
#(
    // Lanes of reads still waiting for data
    parameter int RD_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset_n,

    // Host side, 64-bit byte addressed
    input  logic [31:0] host_address,
    input  logic        host_read,
    input  logic        host_write,
    input  logic [63:0] host_writedata,
    input  logic [7:0]  host_byteenable,
    output logic        host_waitrequest,
    output logic [63:0] host_readdata,
    output logic        host_readdatavalid,

    mmio_avalon_if.requester bus
);

    localparam int PTR_W = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;

    // ========================================
    // Request path
    // ========================================

    // 64-bit lane inside the 512-bit word
    logic [2:0] lane;

    assign lane = host_address[5:3];

    // Purely combinational, the host sees the bus stall directly
    assign bus.address    = host_address[17:6];
    assign bus.read       = host_read;
    assign bus.write      = host_write;
    assign host_waitrequest = bus.waitrequest;

    // Shift enables by 8 bytes per lane
    assign bus.byteenable = t_byte_mask'(host_byteenable) << {lane, 3'b000};

    // Data goes to the same lane, other lanes zero
    assign bus.writedata.bits = 512'(host_writedata) << {lane, 6'b000000};

    // ========================================
    // Lane FIFO for reads in flight
    // ========================================

    logic [2:0]       lane_mem [RD_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             rd_push;

    // Wrap at RD_DEPTH, need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RD_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Push on the accepting edge of a read
    assign rd_push = host_read && !bus.waitrequest;

    always_ff @(posedge clk)
    begin
        if (rd_push)
        begin
            lane_mem[wr_ptr_q] <= lane;
        end
    end

    // Data returns in order, so each valid pops the oldest lane
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (rd_push)
            begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (bus.readdatavalid)
            begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
        end
    end

    // ========================================
    // Response path
    // ========================================

    // Same cycle as the wide valid, no extra register
    assign host_readdatavalid = bus.readdatavalid;
    assign host_readdata      = bus.readdata.words[lane_mem[rd_ptr_q]];

endmodule

/* source/csr_write_capture.sv */
// Write capture register

`timescale 1ns/1ps

module csr_write_capture
    import mmio_csr_pkg::*;
(
    mmio_avalon_if.capture bus,
    output t_wr_state      wr_state
);

    // ========================================
    // Accepted write detect
    // ========================================

    logic      wr_accept;
    t_wr_state state_q;

    // Same acceptance rule as every other bus user
    assign wr_accept = bus.write && !bus.waitrequest;

    // ========================================
    // Merge and record
    // ========================================

    // Readback starts as all ones so an untouched register is obvious
    always_ff @(posedge bus.clk)
    begin
        if (!bus.reset_n)
        begin
            state_q <= '1;
        end
        else if (wr_accept)
        begin
            // Only enabled bytes change, the rest keep older data
            for (int i = 0; i < 64; i++)
            begin
                if (bus.byteenable[i])
                begin
                    state_q.data.bits[i*8 +: 8] <= bus.writedata.bits[i*8 +: 8];
                end
            end

            // Mask and index of the last write only
            state_q.mask <= bus.byteenable;
            state_q.idx  <= bus.address;

            // Empty mask wraps to offset 0
            state_q.byte_idx <= 6'(lowest_byte(bus.byteenable));
        end
    end

    assign wr_state = state_q;

endmodule

/* source/csr_read_mux.sv */
// Two-stage CSR read pipeline
// Feature header, status and write readback

`timescale 1ns/1ps

module csr_read_mux
    import mmio_csr_pkg::*;
#(
    parameter logic [127:0] AFU_ID  = 128'h0,
    parameter logic [15:0]  CLK_MHZ = 16'd250
) (
    mmio_avalon_if.responder bus,
    input  t_wr_state        wr_state
);

    // ========================================
    // Stage one
    // ========================================

    logic        read_q;
    t_csr_idx    idx_q;
    t_mmio_value feature;
    t_mmio_value feature_q;
    logic [31:0] req_byte_addr;

    // Full byte address of the request, index plus byte offset
    assign req_byte_addr = 32'({bus.address, 6'(lowest_byte(bus.byteenable))});

    // Feature header block, built from the live request
    always_comb
    begin
        feature = '0;
        // Feature type AFU
        feature.words[0][63:60] = 4'h1;
        // Only entry, so end of list
        feature.words[0][40] = 1'b1;
        // Identifier, low half first
        feature.words[1] = AFU_ID[63:0];
        feature.words[2] = AFU_ID[127:64];
        // Address twice so either 32-bit half reads it
        feature.words[7] = {req_byte_addr, req_byte_addr};
    end

    always_ff @(posedge bus.clk)
    begin
        if (!bus.reset_n)
        begin
            read_q <= 1'b0;
        end
        else
        begin
            read_q <= bus.read && !bus.waitrequest;
        end
    end

    // Payload side, qualified by read_q
    always_ff @(posedge bus.clk)
    begin
        idx_q     <= bus.address;
        feature_q <= feature;
    end

    // ========================================
    // Stage two
    // ========================================

    logic [63:0] status_word;
    logic [63:0] wr_info;
    logic [2:0]  wr_lane;
    t_mmio_value rd_value;

    // Clock rate, 512-bit bus code, 512-bit write support
    assign status_word = {32'h0, CLK_MHZ, 2'h3, 9'h0, 1'b1, 4'h0};

    // Lane of the captured write, from its byte offset
    assign wr_lane = wr_state.byte_idx[5:3];
    assign wr_info = 64'({wr_state.idx, wr_state.byte_idx});

    always_comb
    begin
        rd_value = '0;
        case (idx_q)
            IDX_DFH:        rd_value = feature_q;
            IDX_STATUS:     rd_value.words[0] = status_word;
            // Narrow view, behaves like a 64-bit register
            IDX_WR64_DATA:  rd_value.words[0] = wr_state.data.words[wr_lane];
            IDX_WR64_INFO:
            begin
                rd_value.words[0] = wr_info;
                rd_value.words[1] = 64'(wr_state.mask[{wr_lane, 3'b000} +: 8]);
            end
            // Wide view, eight registers in one word
            IDX_WR512_DATA: rd_value = wr_state.data;
            IDX_WR512_INFO:
            begin
                rd_value.words[0] = wr_info;
                rd_value.words[1] = wr_state.mask;
            end
            default:        rd_value = '0;
        endcase
    end

    always_ff @(posedge bus.clk)
    begin
        if (!bus.reset_n)
        begin
            bus.readdatavalid <= 1'b0;
        end
        else
        begin
            bus.readdatavalid <= read_q;
        end
    end

    always_ff @(posedge bus.clk)
    begin
        bus.readdata <= rd_value;
    end

endmodule

/* source/mmio_csr_top.sv */
// MMIO test register block top

`timescale 1ns/1ps

module mmio_csr_top #(
    parameter logic [127:0] AFU_ID        = 128'h5f3a_91c2_7d04_4e8b_a1f6_03c9_b82e_d417,
    // Reported in the status register
    parameter logic [15:0]  CLK_MHZ       = 16'd250,
    // All ones but bit 0, one free slot in sixteen
    parameter logic [15:0]  STALL_PATTERN = 16'hfffe,
    parameter int           RD_DEPTH      = 4
) (
    input  logic        clk,
    input  logic        reset_n,

    // Host MMIO port
    input  logic [31:0] host_address,
    input  logic        host_read,
    input  logic        host_write,
    input  logic [63:0] host_writedata,
    input  logic [7:0]  host_byteenable,
    output logic        host_waitrequest,
    output logic [63:0] host_readdata,
    output logic        host_readdatavalid
);

    // ========================================
    // Wide bus and its users
    // ========================================

    mmio_avalon_if i_bus (
        .clk     (clk),
        .reset_n (reset_n)
    );

    // Stall source for the whole bus
    mmio_stall_gen #(
        .STALL_PATTERN (STALL_PATTERN)
    ) i_stall_gen (
        .bus (i_bus.stall)
    );

    // Only requester on the wide bus
    mmio_width_adapter #(
        .RD_DEPTH (RD_DEPTH)
    ) i_width_adapter (
        .clk                (clk),
        .reset_n            (reset_n),
        .host_address       (host_address),
        .host_read          (host_read),
        .host_write         (host_write),
        .host_writedata     (host_writedata),
        .host_byteenable    (host_byteenable),
        .host_waitrequest   (host_waitrequest),
        .host_readdata      (host_readdata),
        .host_readdatavalid (host_readdatavalid),
        .bus                (i_bus.requester)
    );

    // Write state shared between capture and readback
    mmio_csr_pkg::t_wr_state wr_state;

    csr_write_capture i_write_capture (
        .bus      (i_bus.capture),
        .wr_state (wr_state)
    );

    csr_read_mux #(
        .AFU_ID  (AFU_ID),
        .CLK_MHZ (CLK_MHZ)
    ) i_read_mux (
        .bus      (i_bus.responder),
        .wr_state (wr_state)
    );

endmodule

/* verif/tb_mmio_csr_ref.svh */
// Shadow write state and read reference

`ifndef TB_MMIO_CSR_REF_SVH
`define TB_MMIO_CSR_REF_SVH

// ========================================
// Register map, wide word indexes
// ========================================

localparam logic [11:0] MAP_DFH        = 12'd0;
localparam logic [11:0] MAP_STATUS     = 12'd2;
localparam logic [11:0] MAP_WR64_DATA  = 12'd4;
localparam logic [11:0] MAP_WR64_INFO  = 12'd6;
localparam logic [11:0] MAP_WR512_DATA = 12'd8;
localparam logic [11:0] MAP_WR512_INFO = 12'd10;

// Shadow of the last write, all ones out of reset
logic [511:0] sh_data;
logic [63:0]  sh_mask;
logic [11:0]  sh_idx;
logic [5:0]   sh_byte_idx;

function automatic void clear_shadow();
    sh_data     = '1;
    sh_mask     = '1;
    sh_idx      = '1;
    sh_byte_idx = '1;
endfunction

// First set enable bit, 64 for an empty mask
function automatic int lowest_enable(input logic [63:0] mask);
    int pos;
    pos = 64;
    for (int i = 0; i < 64; i++)
    begin
        if (mask[i] && pos == 64)
        begin
            pos = i;
        end
    end
    return pos;
endfunction

// Byte merge of one host write into the wide word
function automatic void merge_write(input logic [31:0] addr, input logic [63:0] data,
                                    input logic [7:0] be);
    logic [2:0] lane;
    int         pos;
    lane = addr[5:3];
    for (int j = 0; j < 8; j++)
    begin
        if (be[j])
        begin
            // Byte j of the host word lands in byte 8*lane+j of the wide word
            pos = 8 * int'(lane) + j;
            sh_data[8*pos +: 8] = data[8*j +: 8];
        end
    end
    sh_mask     = {56'h0, be} << {lane, 3'b000};
    sh_idx      = addr[17:6];
    sh_byte_idx = 6'(lowest_enable(sh_mask));
endfunction

// Expected 64-bit host read value
function automatic logic [63:0] expected_read(input logic [31:0] addr, input logic [7:0] be);
    logic [11:0] idx;
    logic [2:0]  lane;
    logic [63:0] wide_be;
    logic [31:0] req_addr;
    logic [63:0] info;
    logic [63:0] value;
    int          wlane;
    idx      = addr[17:6];
    lane     = addr[5:3];
    wide_be  = {56'h0, be} << {lane, 3'b000};
    // Byte address of the request itself
    req_addr = 32'(idx) * 32'd64 + 32'(lowest_enable(wide_be));
    // Lane of the captured write
    wlane    = int'(sh_byte_idx[5:3]);
    info     = {46'h0, sh_idx, sh_byte_idx};
    value    = '0;
    case (idx)
        MAP_DFH:
        begin
            case (lane)
                // AFU type, end of list
                3'd0:    value = (64'h1 << 60) | (64'h1 << 40);
                3'd1:    value = AFU_ID[63:0];
                3'd2:    value = AFU_ID[127:64];
                3'd7:    value = {req_addr, req_addr};
                default: value = '0;
            endcase
        end
        MAP_STATUS:
        begin
            if (lane == 3'd0)
            begin
                value = (64'(CLK_MHZ) << 16) | (64'h3 << 14) | (64'h1 << 4);
            end
        end
        MAP_WR64_DATA:
        begin
            if (lane == 3'd0)
            begin
                value = sh_data[64*wlane +: 64];
            end
        end
        MAP_WR64_INFO:
        begin
            case (lane)
                3'd0:    value = info;
                3'd1:    value = {56'h0, sh_mask[8*wlane +: 8]};
                default: value = '0;
            endcase
        end
        MAP_WR512_DATA: value = sh_data[64*int'(lane) +: 64];
        MAP_WR512_INFO:
        begin
            case (lane)
                3'd0:    value = info;
                3'd1:    value = sh_mask;
                default: value = '0;
            endcase
        end
        default: value = '0;
    endcase
    return value;
endfunction

`endif

/* verif/tb_mmio_csr.sv */
// MMIO register block testbench

`timescale 1ns/1ps

module tb_mmio_csr;

    localparam logic [127:0] AFU_ID        = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    localparam logic [15:0]  CLK_MHZ       = 16'd300;
    localparam logic [15:0]  STALL_PATTERN = 16'hfffe;
    // Reads and writes issued by the sequences below
    localparam int NUM_TXN        = 185;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 20 + 200;

    logic        clk;
    logic        reset_n;
    logic [31:0] host_address;
    logic        host_read;
    logic        host_write;
    logic [63:0] host_writedata;
    logic [7:0]  host_byteenable;
    logic        host_waitrequest;
    logic [63:0] host_readdata;
    logic        host_readdatavalid;

    `include "tb_mmio_csr_ref.svh"

    // Outstanding reads, oldest first
    logic [63:0] exp_data_q[$];
    logic [31:0] exp_addr_q[$];
    int          accept_cycle_q[$];

    int          cycle_count = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          reads_issued = 0;
    int          valid_count = 0;
    logic [31:0] rng_state = 32'h4439;

    mmio_csr_top #(
        .AFU_ID        (AFU_ID),
        .CLK_MHZ       (CLK_MHZ),
        .STALL_PATTERN (STALL_PATTERN),
        .RD_DEPTH      (4)
    ) i_mmio_csr_top (
        .clk                (clk),
        .reset_n            (reset_n),
        .host_address       (host_address),
        .host_read          (host_read),
        .host_write         (host_write),
        .host_writedata     (host_writedata),
        .host_byteenable    (host_byteenable),
        .host_waitrequest   (host_waitrequest),
        .host_readdata      (host_readdata),
        .host_readdatavalid (host_readdatavalid)
    );

    // ========================================
    // Clock, cycle count, helpers
    // ========================================

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Host byte address of one lane of a wide word
    function automatic logic [31:0] lane_address(input logic [11:0] idx, input logic [2:0] lane);
        return {14'h0, idx, lane, 3'b000};
    endfunction

    // Drive at the falling edge, hold until a rising edge without stall
    task automatic issue_read(input logic [31:0] addr, input logic [7:0] be);
        @(negedge clk);
        host_address    = addr;
        host_byteenable = be;
        host_writedata  = '0;
        host_read       = 1'b1;
        host_write      = 1'b0;
        while (host_waitrequest)
        begin
            @(negedge clk);
        end
        // Cycle in which the read is presented, taken at the next rising edge
        exp_data_q.push_back(expected_read(addr, be));
        exp_addr_q.push_back(addr);
        accept_cycle_q.push_back(cycle_count);
        reads_issued++;
        @(posedge clk);
    endtask

    task automatic issue_write(input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] be);
        @(negedge clk);
        host_address    = addr;
        host_byteenable = be;
        host_writedata  = data;
        host_read       = 1'b0;
        host_write      = 1'b1;
        while (host_waitrequest)
        begin
            @(negedge clk);
        end
        merge_write(addr, data, be);
        @(posedge clk);
    endtask

    task automatic write_random();
        logic [31:0] r;
        logic [7:0]  be;
        logic [63:0] data;
        r  = next_random();
        be = r[23:16];
        // Never an empty mask
        if (be == 8'h00)
        begin
            be = 8'h01;
        end
        data = {next_random(), next_random()};
        issue_write(lane_address(r[11:0], r[14:12]), data, be);
    endtask

    task automatic go_idle();
        @(negedge clk);
        host_read  = 1'b0;
        host_write = 1'b0;
    endtask

    // ========================================
    // Response checker
    // ========================================

    always @(negedge clk)
    begin : compare_responses
        logic [63:0] exp_data;
        logic [31:0] exp_addr;
        int          accept_cycle;
        if (reset_n && host_readdatavalid)
        begin
            valid_count++;
            if (exp_data_q.size() == 0)
            begin
                protocol_errors++;
                $display("Read data returned with no read outstanding");
            end
            else
            begin
                exp_data     = exp_data_q.pop_front();
                exp_addr     = exp_addr_q.pop_front();
                accept_cycle = accept_cycle_q.pop_front();
                assert (host_readdata === exp_data)
                else
                begin
                    value_errors++;
                    $display("[FAIL] host_readdata=%h expected=%h address=%h",
                             host_readdata, exp_data, exp_addr);
                end
                // Fixed two-clock read latency
                assert (cycle_count - accept_cycle == 2)
                else
                begin
                    protocol_errors++;
                    $display("Read of address %h returned %0d cycles after acceptance, not 2",
                             exp_addr, cycle_count - accept_cycle);
                end
            end
        end
    end

    // ========================================
    // Timeout
    // ========================================

    initial
    begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Run timed out after %0d cycles with %0d reads still outstanding",
                 cycle_count, exp_data_q.size());
        $display("Errors: value %0d, protocol %0d", value_errors, protocol_errors);
        $display("Test failed");
        $finish;
    end

    // ========================================
    // Test sequences
    // ========================================

    initial
    begin : main_sequence
        logic [31:0] r;
        logic [7:0]  be;
        logic [11:0] idx;
        reset_n         = 1'b0;
        host_address    = '0;
        host_read       = 1'b0;
        host_write      = 1'b0;
        host_writedata  = '0;
        host_byteenable = '0;
        clear_shadow();

        // Outputs quiet while in reset
        repeat (16)
        begin
            @(negedge clk);
            assert (host_readdatavalid === 1'b0)
            else
            begin
                protocol_errors++;
                $display("[FAIL] host_readdatavalid=%h expected=0 in reset", host_readdatavalid);
            end
            assert (host_waitrequest === 1'b1)
            else
            begin
                protocol_errors++;
                $display("[FAIL] host_waitrequest=%h expected=1 in reset", host_waitrequest);
            end
        end
        reset_n = 1'b1;

        // First free slot eight cycles after release
        for (int i = 1; i <= 8; i++)
        begin
            @(negedge clk);
            assert (host_waitrequest === (i < 8))
            else
            begin
                protocol_errors++;
                $display("[FAIL] host_waitrequest=%h expected=%h at cycle %0d after reset",
                         host_waitrequest, (i < 8), i);
            end
        end

        // Feature header, identifier, request address
        for (int lane = 0; lane < 8; lane++)
        begin
            issue_read(lane_address(MAP_DFH, 3'(lane)), 8'hff);
        end
        repeat (8)
        begin
            r  = next_random();
            be = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
            issue_read(lane_address(MAP_DFH, 3'd7), be);
        end

        // Status word, unmapped indexes
        for (int lane = 0; lane < 8; lane++)
        begin
            issue_read(lane_address(MAP_STATUS, 3'(lane)), 8'hff);
        end
        for (int i = 0; i < 6; i++)
        begin
            r = next_random();
            issue_read(lane_address(12'(2 * i + 1), r[2:0]), 8'hff);
        end
        issue_read(lane_address(12'h7ff, 3'd0), 8'hff);
        issue_read(lane_address(12'hfff, 3'd5), 8'hff);

        // Untouched capture reads as all ones
        issue_read(lane_address(MAP_WR64_DATA, 3'd0), 8'hff);
        issue_read(lane_address(MAP_WR64_INFO, 3'd0), 8'hff);
        issue_read(lane_address(MAP_WR64_INFO, 3'd1), 8'hff);
        for (int lane = 0; lane < 8; lane++)
        begin
            issue_read(lane_address(MAP_WR512_DATA, 3'(lane)), 8'hff);
        end
        issue_read(lane_address(MAP_WR512_INFO, 3'd0), 8'hff);
        issue_read(lane_address(MAP_WR512_INFO, 3'd1), 8'hff);

        // Narrow readback after random writes
        repeat (6)
        begin
            write_random();
            issue_read(lane_address(MAP_WR64_DATA, 3'd0), 8'hff);
            issue_read(lane_address(MAP_WR64_DATA, 3'd1), 8'hff);
            for (int lane = 0; lane < 3; lane++)
            begin
                issue_read(lane_address(MAP_WR64_INFO, 3'(lane)), 8'hff);
            end
        end

        // Wide readback, byte merge across lanes
        repeat (8)
        begin
            write_random();
            for (int lane = 0; lane < 8; lane++)
            begin
                issue_read(lane_address(MAP_WR512_DATA, 3'(lane)), 8'hff);
            end
            issue_read(lane_address(MAP_WR512_INFO, 3'd0), 8'hff);
            issue_read(lane_address(MAP_WR512_INFO, 3'd1), 8'hff);
        end

        // Back-to-back reads of mapped registers
        repeat (16)
        begin
            r   = next_random();
            idx = 12'(2 * (r % 6));
            issue_read(lane_address(idx, r[10:8]), 8'hff);
        end
        go_idle();

        // Drain, then look for stray responses
        while (exp_data_q.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (valid_count == reads_issued)
        else
        begin
            protocol_errors++;
            $display("Issued %0d reads but saw %0d responses", reads_issued, valid_count);
        end

        $display("Errors: value %0d, protocol %0d, reads %0d, responses %0d",
                 value_errors, protocol_errors, reads_issued, valid_count);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+verif
source/mmio_csr_pkg.sv
source/mmio_avalon_if.sv
source/mmio_stall_gen.sv
source/mmio_width_adapter.sv
source/csr_write_capture.sv
source/csr_read_mux.sv
source/mmio_csr_top.sv
verif/tb_mmio_csr.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MMIO register block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_mmio_csr \
    -f tb.f \
    --Mdir obj_dir

./obj_dir/Vtb_mmio_csr | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
